//--- build.f
design/arb_pkg.sv
design/req_queue.sv
design/rr_arbiter.sv
design/grant_out_stage.sv
design/packet_arbiter_top.sv
sim/arb_checker.sv
sim/arb_monitor.sv
sim/tb_top.sv

//--- design/arb_pkg.sv
`default_nettype none

package arb_pkg;

    // Number of requesting sources in front of the shared port
    localparam int num_srcs = 4;
    localparam int src_idx_w = $clog2(num_srcs);

    // Each source owns a small request queue of this many beats
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = $clog2(queue_depth);
    localparam int queue_cnt_w = $clog2(queue_depth + 1);

    // One beat of a packet; last closes the packet and releases the arbiter lock
    typedef struct packed {
        logic [15:0] addr_tag;
        logic [15:0] data;
        logic        last;
    } req_payload_t;

endpackage

`default_nettype wire

//--- design/grant_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module grant_out_stage #(
    parameter type payload_t = arb_pkg::req_payload_t
) (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire payload_t [arb_pkg::num_srcs-1:0]        heads,
    input  wire logic     [arb_pkg::num_srcs-1:0]        grant_onehot,
    input  wire logic     [arb_pkg::src_idx_w-1:0]       grant_index,
    input  wire logic                                    grant_valid,
    output logic          [arb_pkg::num_srcs-1:0]        pop,
    output logic                                         unlock,
    output logic                                         out_valid,
    output payload_t                                     out_payload,
    output logic          [arb_pkg::src_idx_w-1:0]       out_src
);
    import arb_pkg::*;

    payload_t sel_head;

    assign sel_head = heads[grant_index];

    assign pop    = grant_onehot & {num_srcs{grant_valid}};
    // Releasing on the last beat lets the next packet win on the following cycle
    assign unlock = grant_valid && sel_head.last;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= grant_valid;
        end
    end

    // Payload and source hold between beats
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            out_payload <= sel_head;
            out_src     <= grant_index;
        end
    end

endmodule

`default_nettype wire

//--- design/packet_arbiter_top.sv
`timescale 1ns/1ps
`default_nettype none

module packet_arbiter_top (
    input  wire logic                                       clk,
    input  wire logic                                       reset,
    input  wire logic                 [arb_pkg::num_srcs-1:0] push,
    input  wire arb_pkg::req_payload_t [arb_pkg::num_srcs-1:0] push_data,
    output logic                                            out_valid,
    output arb_pkg::req_payload_t                           out_payload,
    output logic                      [arb_pkg::src_idx_w-1:0] out_src,
    output logic                      [arb_pkg::num_srcs-1:0] overflow
);
    import arb_pkg::*;

    req_payload_t [num_srcs-1:0] heads;
    logic [num_srcs-1:0]         empty;
    logic [num_srcs-1:0]         pop;
    logic [num_srcs-1:0]         grant_onehot;
    logic [src_idx_w-1:0]        grant_index;
    logic                        grant_valid;
    logic                        unlock;

    for (genvar i = 0; i < num_srcs; i++) begin : g_queue
        req_queue #(
            .payload_t (req_payload_t)
        ) i_queue (
            .clk       (clk),
            .reset     (reset),
            .push      (push[i]),
            .push_data (push_data[i]),
            .pop       (pop[i]),
            .head      (heads[i]),
            .empty     (empty[i]),
            .overflow  (overflow[i])
        );
    end

    rr_arbiter #(
        .lock_enable (1'b1)
    ) i_arbiter (
        .clk          (clk),
        .reset        (reset),
        .unlock       (unlock),
        .requests     (~empty),
        .grant_index  (grant_index),
        .grant_onehot (grant_onehot),
        .grant_valid  (grant_valid)
    );

    grant_out_stage #(
        .payload_t (req_payload_t)
    ) i_out_stage (
        .clk          (clk),
        .reset        (reset),
        .heads        (heads),
        .grant_onehot (grant_onehot),
        .grant_index  (grant_index),
        .grant_valid  (grant_valid),
        .pop          (pop),
        .unlock       (unlock),
        .out_valid    (out_valid),
        .out_payload  (out_payload),
        .out_src      (out_src)
    );

endmodule

`default_nettype wire

//--- design/req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter type payload_t = arb_pkg::req_payload_t
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      head,
    output logic          empty,
    output logic          overflow
);
    import arb_pkg::*;

    payload_t mem [queue_depth];

    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_cnt_w-1:0] count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign empty = (count == '0);
    assign full  = (count == queue_cnt_w'(queue_depth));

    // A pop in the same cycle frees the slot, so a full queue can still take a push
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                if (wr_ptr == queue_ptr_w'(queue_depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            if (do_pop) begin
                if (rd_ptr == queue_ptr_w'(queue_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // A dropped beat keeps the flag up until reset
            if (push && !do_push) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter bit lock_enable = 1'b0
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          unlock,
    input  wire logic [arb_pkg::num_srcs-1:0]  requests,
    output logic      [arb_pkg::src_idx_w-1:0] grant_index,
    output logic      [arb_pkg::num_srcs-1:0]  grant_onehot,
    output logic                               grant_valid
);
    import arb_pkg::*;

    logic [num_srcs-1:0] pointer_reg;
    logic [num_srcs-1:0] req_masked;
    logic [num_srcs-1:0] mask_higher_pri;
    logic [num_srcs-1:0] unmask_higher_pri;
    logic [num_srcs-1:0] grant_masked;
    logic [num_srcs-1:0] grant_unmasked;
    logic                no_req_masked;

    assign req_masked    = requests & pointer_reg;
    assign no_req_masked = ~(|req_masked);

    // Bit i of each chain is set when some lower index already requests,
    // so the chain also marks every source above the winner
    always_comb begin
        logic seen_masked;
        logic seen_unmasked;
        seen_masked   = 1'b0;
        seen_unmasked = 1'b0;
        for (int i = 0; i < num_srcs; i++) begin
            mask_higher_pri[i]   = seen_masked;
            unmask_higher_pri[i] = seen_unmasked;
            seen_masked          = seen_masked | req_masked[i];
            seen_unmasked        = seen_unmasked | requests[i];
        end
    end

    assign grant_masked   = req_masked & ~mask_higher_pri;
    assign grant_unmasked = requests & ~unmask_higher_pri;

    // Fall back to the plain priority chain when nobody is inside the mask
    assign grant_onehot = ({num_srcs{no_req_masked}} & grant_unmasked) | grant_masked;
    assign grant_valid  = |requests;

    always_comb begin
        grant_index = '0;
        for (int i = 0; i < num_srcs; i++) begin
            if (grant_onehot[i]) begin
                grant_index = src_idx_w'(i);
            end
        end
    end

    // With the lock on, the pointer only moves once the packet ends
    always_ff @(posedge clk) begin
        if (reset) begin
            pointer_reg <= '1;
        end else if (!lock_enable || unlock) begin
            if (!no_req_masked) begin
                pointer_reg <= mask_higher_pri;
            end else if (grant_valid) begin
                pointer_reg <= unmask_higher_pri;
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the packet arbiter testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f build.f \
    && ./obj_dir/Vtb_top | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/arb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module arb_checker (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [arb_pkg::num_srcs-1:0]  pop,
    input  wire logic                          out_valid,
    input  wire arb_pkg::req_payload_t         out_payload,
    input  wire logic [arb_pkg::src_idx_w-1:0] out_src
);
    import arb_pkg::*;

    logic had_beat;
    logic out_last;
    int   fail_count = 0;

    assign out_last = out_payload.last;

    // The first beat after reset has no earlier source to compare against
    always_ff @(posedge clk) begin
        if (reset) begin
            had_beat <= 1'b0;
        end else if (out_valid) begin
            had_beat <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(pop))
        else begin
            fail_count++;
            $error("pop selects more than one queue");
        end

    assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after reset");
        end

    // A packet holds the output until its last beat has left
    assert property (@(posedge clk) disable iff (reset)
        (out_valid && had_beat && (out_src != $past(out_src))) |-> $past(out_last))
        else begin
            fail_count++;
            $error("out_src changed in the middle of a packet");
        end

endmodule

`default_nettype wire

//--- sim/arb_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module arb_monitor (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    input  wire logic                  [arb_pkg::num_srcs-1:0]  push,
    input  wire arb_pkg::req_payload_t [arb_pkg::num_srcs-1:0]  push_data,
    input  wire logic                                          out_valid,
    input  wire arb_pkg::req_payload_t                         out_payload,
    input  wire logic                  [arb_pkg::src_idx_w-1:0] out_src,
    input  wire logic                  [arb_pkg::num_srcs-1:0]  overflow,
    input  wire logic                                          test_done,
    input  wire logic                                          run_end,
    input  wire logic                  [7:0]                    test_num,
    input  wire logic                  [7:0]                    exp_beats,
    input  wire logic                  [arb_pkg::num_srcs-1:0]  exp_ovf,
    output logic                                               drained,
    output logic                       [15:0]                   error_count
);
    import arb_pkg::*;

    req_payload_t         model_q [num_srcs][$];
    logic [num_srcs-1:0]  model_ptr;
    logic [num_srcs-1:0]  model_ovf;
    int                   wait_pkts [num_srcs];
    logic                 exp_valid;
    req_payload_t         exp_payload;
    logic [src_idx_w-1:0] exp_src;
    int                   beats_seen;
    logic [15:0]          errors_at_start;
    int                   tests_run;
    int                   tests_failed;

    // Lowest requester inside the priority mask, else the lowest requester overall
    function automatic int pick_winner(input logic [num_srcs-1:0] req,
                                       input logic [num_srcs-1:0] ptr);
        int winner;
        winner = -1;
        for (int i = num_srcs - 1; i >= 0; i--) begin
            if (req[i]) begin
                winner = i;
            end
        end
        for (int i = num_srcs - 1; i >= 0; i--) begin
            if (req[i] && ptr[i]) begin
                winner = i;
            end
        end
        return winner;
    endfunction

    task automatic report_value(input string name, input logic [32:0] exp,
                                input logic [32:0] act);
        $display("Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
        error_count = error_count + 16'd1;
    endtask

    task automatic end_test();
        if (beats_seen != int'(exp_beats)) begin
            report_value("out_valid beats", 33'(exp_beats), 33'(beats_seen));
        end
        if (overflow !== exp_ovf) begin
            report_value("overflow", 33'(exp_ovf), 33'(overflow));
        end
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
        end
        $display("Test %0d: %0d beats, %s", test_num, beats_seen,
                 (error_count == errors_at_start) ? "pass" : "fail");
        beats_seen = 0;
        errors_at_start = error_count;
    endtask

    always @(posedge clk) begin
        int                  w;
        logic [num_srcs-1:0] req;
        req_payload_t        beat;
        if (reset) begin
            for (int i = 0; i < num_srcs; i++) begin
                model_q[i].delete();
                wait_pkts[i] = 0;
            end
            model_ptr       = '1;
            model_ovf       = '0;
            exp_valid       = 1'b0;
            drained         = 1'b1;
            error_count     = '0;
            errors_at_start = '0;
            beats_seen      = 0;
            tests_run       = 0;
            tests_failed    = 0;
        end else begin
            // The output register shows the beat granted one edge earlier
            if (out_valid) begin
                beats_seen++;
            end
            if (out_valid !== exp_valid) begin
                report_value("out_valid", 33'(exp_valid), 33'(out_valid));
            end else if (exp_valid) begin
                if (out_src !== exp_src) begin
                    report_value("out_src", 33'(exp_src), 33'(out_src));
                end
                if (out_payload !== exp_payload) begin
                    report_value("out_payload", exp_payload, out_payload);
                end
            end
            if (overflow !== model_ovf) begin
                report_value("overflow", 33'(model_ovf), 33'(overflow));
            end
            if (test_done) begin
                end_test();
            end
            if (run_end) begin
                $display("Summary: %0d tests, %0d failed, %0d errors",
                         tests_run, tests_failed, error_count);
            end

            for (int i = 0; i < num_srcs; i++) begin
                req[i] = (model_q[i].size() != 0);
            end
            w = pick_winner(req, model_ptr);
            exp_valid = (w >= 0);
            if (w >= 0) begin
                beat        = model_q[w].pop_front();
                exp_payload = beat;
                exp_src     = src_idx_w'(w);
                if (beat.last) begin
                    // Every source still holding data was passed over once more
                    for (int i = 0; i < num_srcs; i++) begin
                        if (i == w || model_q[i].size() == 0) begin
                            wait_pkts[i] = 0;
                        end else begin
                            wait_pkts[i]++;
                        end
                        if (wait_pkts[i] > num_srcs - 1) begin
                            $display("Source %0d was passed over for %0d packets in a row",
                                     i, wait_pkts[i]);
                            error_count = error_count + 16'd1;
                        end
                    end
                    for (int j = 0; j < num_srcs; j++) begin
                        model_ptr[j] = (j > w);
                    end
                end
            end

            // Pushes land after the pop, so a full queue that is popped still takes one
            drained = !exp_valid;
            for (int i = 0; i < num_srcs; i++) begin
                if (push[i]) begin
                    if (model_q[i].size() < queue_depth) begin
                        model_q[i].push_back(push_data[i]);
                    end else begin
                        model_ovf[i] = 1'b1;
                    end
                end
                if (model_q[i].size() != 0) begin
                    drained = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/arb_stim.txt
# P test push(hex), then tag(hex) data(hex) last for sources 0, 1, 2 and 3; one line per clock
# E test expected_beats expected_overflow(hex); waits for the output to drain
P 1 8 0000 0000 0 0000 0000 0 0000 0000 0 0130 beef 1
E 1 1 0
P 2 f 0200 1111 1 0210 2222 1 0220 3333 1 0230 4444 1
P 2 f 0201 5555 1 0211 6666 1 0221 7777 1 0231 8888 1
E 2 8 0
P 3 1 0300 a000 1 0000 0000 0 0000 0000 0 0000 0000 0
P 3 7 0301 a001 1 0310 b000 0 0320 c000 1 0000 0000 0
P 3 2 0000 0000 0 0311 b001 0 0000 0000 0 0000 0000 0
P 3 2 0000 0000 0 0312 b002 1 0000 0000 0 0000 0000 0
E 3 6 0
P 4 f 0400 d000 0 0410 d100 0 0420 d200 0 0430 d300 0
P 4 f 0401 d001 1 0411 d101 1 0421 d201 1 0431 d301 1
P 4 f 0402 d002 0 0412 d102 0 0422 d202 0 0432 d302 0
P 4 f 0403 d003 1 0413 d103 1 0423 d203 1 0433 d303 1
E 4 16 0
P 5 2 0000 0000 0 0510 e000 0 0000 0000 0 0000 0000 0
P 5 6 0000 0000 0 0511 e001 0 0520 f000 1 0000 0000 0
P 5 6 0000 0000 0 0512 e002 0 0521 f001 1 0000 0000 0
P 5 6 0000 0000 0 0513 e003 0 0522 f002 1 0000 0000 0
P 5 6 0000 0000 0 0514 e004 0 0523 f003 1 0000 0000 0
P 5 6 0000 0000 0 0515 e005 1 0524 f004 1 0000 0000 0
E 5 10 4

//--- sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import arb_pkg::*;

    localparam int    seed          = 12018;
    localparam int    drain_timeout = 100;
    localparam string stim_file     = "sim/arb_stim.txt";

    logic                        clk;
    logic                        reset;
    logic [num_srcs-1:0]         push;
    req_payload_t [num_srcs-1:0] push_data;
    logic                        out_valid;
    req_payload_t                out_payload;
    logic [src_idx_w-1:0]        out_src;
    logic [num_srcs-1:0]         overflow;
    logic                        test_done;
    logic                        run_end;
    logic [7:0]                  test_num;
    logic [7:0]                  exp_beats;
    logic [num_srcs-1:0]         exp_ovf;
    logic                        drained;
    logic [15:0]                 error_count;

    always #4 clk = ~clk;

    packet_arbiter_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_data   (push_data),
        .out_valid   (out_valid),
        .out_payload (out_payload),
        .out_src     (out_src),
        .overflow    (overflow)
    );

    arb_monitor i_monitor (
        .clk         (clk),
        .reset       (reset),
        .push        (push),
        .push_data   (push_data),
        .out_valid   (out_valid),
        .out_payload (out_payload),
        .out_src     (out_src),
        .overflow    (overflow),
        .test_done   (test_done),
        .run_end     (run_end),
        .test_num    (test_num),
        .exp_beats   (exp_beats),
        .exp_ovf     (exp_ovf),
        .drained     (drained),
        .error_count (error_count)
    );

    bind grant_out_stage arb_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .pop         (pop),
        .out_valid   (out_valid),
        .out_payload (out_payload),
        .out_src     (out_src)
    );

    initial begin
        int          fd;
        int          n;
        int          cycles;
        logic [31:0] f [14];
        string       line;
        bit          run_ok;

        clk       = 1'b0;
        reset     = 1'b1;
        push      = '0;
        push_data = '0;
        test_done = 1'b0;
        run_end   = 1'b0;
        test_num  = '0;
        exp_beats = '0;
        exp_ovf   = '0;
        run_ok    = 1'b1;
        n = $urandom(seed);
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", stim_file);
            run_ok = 1'b0;
        end

        while (run_ok && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) == "P") begin
                n = $sscanf(line.substr(1, line.len() - 1),
                            "%d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                            f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                @(negedge clk);
                for (int i = 0; i < num_srcs; i++) begin
                    push[i]               = f[1][i];
                    push_data[i].addr_tag = f[2 + 3 * i][15:0];
                    push_data[i].data     = f[3 + 3 * i][15:0];
                    push_data[i].last     = f[4 + 3 * i][0];
                end
            end else if (n > 0 && line.getc(0) == "E") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%d %d %h", f[0], f[1], f[2]);
                @(negedge clk);
                push = '0;
                cycles = 0;
                while (!drained && cycles < drain_timeout) begin
                    @(negedge clk);
                    cycles++;
                end
                if (!drained) begin
                    $display("Output stalled in test %0d, beats did not leave within %0d cycles",
                             f[0], drain_timeout);
                    run_ok = 1'b0;
                end else begin
                    test_num  = f[0][7:0];
                    exp_beats = f[1][7:0];
                    exp_ovf   = f[2][num_srcs-1:0];
                    test_done = 1'b1;
                    @(negedge clk);
                    test_done = 1'b0;
                    repeat ($urandom_range(6, 1)) @(negedge clk);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(negedge clk);
        run_end = 1'b1;
        @(negedge clk);
        run_end = 1'b0;
        if (run_ok && error_count == 16'd0
                && i_dut.i_out_stage.i_checker.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
